//--- hdl/obuf_regs_pkg.sv
package obuf_regs_pkg;

    ////////////////////
    // Bus widths and basic types
    ////////////////////

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [data_w-1:0] data_t;
    typedef logic [strb_w-1:0] strb_t;

    localparam logic [1:0] resp_okay = 2'b00;

    // Returned for any offset outside the map
    localparam data_t unmapped_data = 32'hDEADBEEF;

    ////////////////////
    // Register map, offsets after the base address is folded out
    ////////////////////

    localparam addr_t reg_id_addr      = 32'h0000_0000;
    localparam addr_t reg_version_addr = 32'h0000_0004;
    localparam addr_t reg_reset_addr   = 32'h0000_0008;
    localparam addr_t reg_flip_addr    = 32'h0000_000C;
    localparam addr_t reg_debug_addr   = 32'h0000_0010;
    localparam addr_t reg_pktin_addr   = 32'h0000_0014;
    localparam addr_t reg_pktout_addr  = 32'h0000_0018;

    // Per-port counters start here, seven words per port
    localparam addr_t reg_port_base_addr = 32'h0000_001C;
    localparam int    counters_per_port  = 7;

    typedef enum logic [2:0] {
        pkt_stored    = 3'd0,
        bytes_stored  = 3'd1,
        pkt_removed   = 3'd2,
        bytes_removed = 3'd3,
        pkt_dropped   = 3'd4,
        bytes_dropped = 3'd5,
        pkt_in_queue  = 3'd6
    } counter_e;

    // Field order follows counter_e
    typedef struct packed {
        data_t pkt_stored;
        data_t bytes_stored;
        data_t pkt_removed;
        data_t bytes_removed;
        data_t pkt_dropped;
        data_t bytes_dropped;
        data_t pkt_in_queue;
    } port_stats_t;

    ////////////////////
    // Requests from the bus side to the register logic
    ////////////////////

    typedef struct packed {
        logic  valid;
        addr_t addr;
        data_t data;
        strb_t strb;
    } wr_req_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } rd_req_t;

    localparam data_t reset_default = 32'h0000_0000;
    localparam data_t flip_default  = 32'h0000_0000;
    localparam data_t debug_default = 32'h0000_0000;

endpackage

//--- hdl/axil_write_channel.sv
`timescale 1ns/100ps

module axil_write_channel #(
    parameter obuf_regs_pkg::addr_t base_address = 32'h0000_0000
) (
    input  logic                   S_AXI_ACLK,
    input  logic                   S_AXI_ARESETN,

    // Write address and data
    input  obuf_regs_pkg::addr_t   awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  obuf_regs_pkg::data_t   wdata,
    input  obuf_regs_pkg::strb_t   wstrb,
    input  logic                   wvalid,
    output logic                   wready,

    // Write response
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,

    // To the control registers
    output obuf_regs_pkg::wr_req_t wr_req
);

    obuf_regs_pkg::addr_t awaddr_q;
    logic                 take;
    logic                 wr_fire;

    // Address and data are taken together, never one without the other
    assign take = ~awready && awvalid && wvalid;

    // Both handshakes complete in the same cycle
    assign wr_fire = awready && awvalid && wready && wvalid;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            awready <= 1'b0;
            wready  <= 1'b0;
        end else begin
            awready <= take;
            wready  <= take;
        end
    end

    // Offset within the block
    always_ff @(posedge S_AXI_ACLK) begin
        if (take) begin
            awaddr_q <= awaddr ^ base_address;
        end
    end

    // One response per write, held until the master takes it
    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            bvalid <= 1'b0;
            bresp  <= obuf_regs_pkg::resp_okay;
        end else begin
            if (wr_fire && ~bvalid) begin
                bvalid <= 1'b1;
                bresp  <= obuf_regs_pkg::resp_okay;
            end else if (bready && bvalid) begin
                bvalid <= 1'b0;
            end
        end
    end

    // Data and strobe are still held by the master during the handshake
    assign wr_req.valid = wr_fire;
    assign wr_req.addr  = awaddr_q;
    assign wr_req.data  = wdata;
    assign wr_req.strb  = wstrb;

endmodule

//--- hdl/axil_read_channel.sv
`timescale 1ns/100ps

module axil_read_channel #(
    parameter obuf_regs_pkg::addr_t base_address = 32'h0000_0000
) (
    input  logic                   S_AXI_ACLK,
    input  logic                   S_AXI_ARESETN,

    // Read address
    input  obuf_regs_pkg::addr_t   araddr,
    input  logic                   arvalid,
    output logic                   arready,

    // Read data
    output obuf_regs_pkg::data_t   rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready,

    // To and from the decode logic
    output obuf_regs_pkg::rd_req_t rd_req,
    input  obuf_regs_pkg::data_t   rd_data
);

    obuf_regs_pkg::addr_t araddr_q;
    logic                 take;
    logic                 rd_fire;

    assign take = ~arready && arvalid;

    // No new request while the previous data is still waiting
    assign rd_fire = arready && arvalid && ~rvalid;

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            arready <= 1'b0;
        end else begin
            arready <= take;
        end
    end

    // Offset within the block
    always_ff @(posedge S_AXI_ACLK) begin
        if (take) begin
            araddr_q <= araddr ^ base_address;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            rvalid <= 1'b0;
            rresp  <= obuf_regs_pkg::resp_okay;
        end else begin
            if (rd_fire) begin
                rvalid <= 1'b1;
                rresp  <= obuf_regs_pkg::resp_okay;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Data stays put until the next request
    always_ff @(posedge S_AXI_ACLK) begin
        if (rd_fire) begin
            rdata <= rd_data;
        end
    end

    assign rd_req.valid = rd_fire;
    assign rd_req.addr  = araddr_q;

endmodule

//--- hdl/obuf_ctrl_regs.sv
`timescale 1ns/100ps

module obuf_ctrl_regs (
    input  logic                   S_AXI_ACLK,
    input  logic                   S_AXI_ARESETN,
    input  obuf_regs_pkg::wr_req_t wr_req,
    output obuf_regs_pkg::data_t   reset_reg,
    output obuf_regs_pkg::data_t   cpu2ip_flip_reg,
    output obuf_regs_pkg::data_t   cpu2ip_debug_reg
);

    logic reset_hit;
    logic flip_hit;
    logic debug_hit;

    // Byte lanes with their strobe set take the new value
    function automatic obuf_regs_pkg::data_t merge_bytes(
        input obuf_regs_pkg::data_t old_val,
        input obuf_regs_pkg::data_t new_val,
        input obuf_regs_pkg::strb_t strb
    );
        obuf_regs_pkg::data_t result;
        result = old_val;
        for (int b = 0; b < obuf_regs_pkg::strb_w; b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = new_val[b*8 +: 8];
            end
        end
        return result;
    endfunction

    ////////////////////
    // Write decode
    ////////////////////

    assign reset_hit = wr_req.valid && (wr_req.addr == obuf_regs_pkg::reg_reset_addr);
    assign flip_hit  = wr_req.valid && (wr_req.addr == obuf_regs_pkg::reg_flip_addr);
    assign debug_hit = wr_req.valid && (wr_req.addr == obuf_regs_pkg::reg_debug_addr);

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            reset_reg        <= obuf_regs_pkg::reset_default;
            cpu2ip_flip_reg  <= obuf_regs_pkg::flip_default;
            cpu2ip_debug_reg <= obuf_regs_pkg::debug_default;
        end else begin
            // Event register, back to default one cycle after the write
            if (reset_hit) begin
                reset_reg <= merge_bytes(obuf_regs_pkg::reset_default, wr_req.data,
                                         wr_req.strb);
            end else begin
                reset_reg <= obuf_regs_pkg::reset_default;
            end

            if (flip_hit) begin
                cpu2ip_flip_reg <= merge_bytes(cpu2ip_flip_reg, wr_req.data, wr_req.strb);
            end

            if (debug_hit) begin
                cpu2ip_debug_reg <= merge_bytes(cpu2ip_debug_reg, wr_req.data, wr_req.strb);
            end
        end
    end

endmodule

//--- hdl/obuf_stats_readback.sv
`timescale 1ns/100ps

module obuf_stats_readback #(
    parameter int num_ports = 5
) (
    input  logic                                      S_AXI_ACLK,
    input  logic                                      S_AXI_ARESETN,
    input  obuf_regs_pkg::rd_req_t                    rd_req,
    output obuf_regs_pkg::data_t                      rd_data,

    // Core side values
    input  obuf_regs_pkg::data_t                      id_reg,
    input  obuf_regs_pkg::data_t                      version_reg,
    input  obuf_regs_pkg::data_t                      ip2cpu_flip_reg,
    input  obuf_regs_pkg::data_t                      ip2cpu_debug_reg,
    input  obuf_regs_pkg::data_t                      pktin_reg,
    input  obuf_regs_pkg::data_t                      pktout_reg,
    input  obuf_regs_pkg::port_stats_t [num_ports-1:0] port_stats,

    // Clear-on-read pulses
    output logic                                      pktin_reg_clear,
    output logic                                      pktout_reg_clear,
    output logic [num_ports-1:0][obuf_regs_pkg::counters_per_port-1:0] port_stats_clear
);

    localparam int num_clears = num_ports * obuf_regs_pkg::counters_per_port + 2;

    logic [num_ports-1:0][obuf_regs_pkg::counters_per_port-1:0] port_hit;
    logic [num_clears-1:0] clear_hit;
    logic [num_clears-1:0] clear_d;
    logic [num_clears-1:0] clear_q;

    function automatic obuf_regs_pkg::data_t stat_word(
        input obuf_regs_pkg::port_stats_t s,
        input obuf_regs_pkg::counter_e    c
    );
        case (c)
            obuf_regs_pkg::pkt_stored:    return s.pkt_stored;
            obuf_regs_pkg::bytes_stored:  return s.bytes_stored;
            obuf_regs_pkg::pkt_removed:   return s.pkt_removed;
            obuf_regs_pkg::bytes_removed: return s.bytes_removed;
            obuf_regs_pkg::pkt_dropped:   return s.pkt_dropped;
            obuf_regs_pkg::bytes_dropped: return s.bytes_dropped;
            default:                      return s.pkt_in_queue;
        endcase
    endfunction

    // Offset match for every per-port counter
    always_comb begin
        for (int n = 0; n < num_ports; n++) begin
            for (int k = 0; k < obuf_regs_pkg::counters_per_port; k++) begin
                port_hit[n][k] = rd_req.addr == obuf_regs_pkg::reg_port_base_addr
                    + obuf_regs_pkg::addr_t'(4 * (n * obuf_regs_pkg::counters_per_port + k));
            end
        end
    end

    ////////////////////
    // Read mux
    ////////////////////

    always_comb begin
        case (rd_req.addr)
            obuf_regs_pkg::reg_id_addr:      rd_data = id_reg;
            obuf_regs_pkg::reg_version_addr: rd_data = version_reg;
            obuf_regs_pkg::reg_flip_addr:    rd_data = ip2cpu_flip_reg;
            obuf_regs_pkg::reg_debug_addr:   rd_data = ip2cpu_debug_reg;
            obuf_regs_pkg::reg_pktin_addr:   rd_data = pktin_reg;
            obuf_regs_pkg::reg_pktout_addr:  rd_data = pktout_reg;
            default:                         rd_data = obuf_regs_pkg::unmapped_data;
        endcase
        for (int n = 0; n < num_ports; n++) begin
            for (int k = 0; k < obuf_regs_pkg::counters_per_port; k++) begin
                if (port_hit[n][k]) begin
                    rd_data = stat_word(port_stats[n], obuf_regs_pkg::counter_e'(k));
                end
            end
        end
    end

    ////////////////////
    // Clear pipeline, two stages
    ////////////////////

    assign clear_hit = {port_hit,
                        rd_req.addr == obuf_regs_pkg::reg_pktout_addr,
                        rd_req.addr == obuf_regs_pkg::reg_pktin_addr};

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            clear_d <= '0;
            clear_q <= '0;
        end else begin
            clear_d <= rd_req.valid ? clear_hit : '0;
            clear_q <= clear_d;
        end
    end

    assign pktin_reg_clear  = clear_q[0];
    assign pktout_reg_clear = clear_q[1];
    assign port_stats_clear = clear_q[num_clears-1:2];

endmodule

//--- hdl/obuf_regs_top.sv
`timescale 1ns/100ps

module obuf_regs_top #(
    parameter obuf_regs_pkg::addr_t base_address = 32'h0000_0000,
    parameter int                   num_ports    = 5
) (
    // AXI-Lite slave
    input  logic                                       S_AXI_ACLK,
    input  logic                                       S_AXI_ARESETN,
    input  obuf_regs_pkg::addr_t                       S_AXI_AWADDR,
    input  logic                                       S_AXI_AWVALID,
    output logic                                       S_AXI_AWREADY,
    input  obuf_regs_pkg::data_t                       S_AXI_WDATA,
    input  obuf_regs_pkg::strb_t                       S_AXI_WSTRB,
    input  logic                                       S_AXI_WVALID,
    output logic                                       S_AXI_WREADY,
    output logic [1:0]                                 S_AXI_BRESP,
    output logic                                       S_AXI_BVALID,
    input  logic                                       S_AXI_BREADY,
    input  obuf_regs_pkg::addr_t                       S_AXI_ARADDR,
    input  logic                                       S_AXI_ARVALID,
    output logic                                       S_AXI_ARREADY,
    output obuf_regs_pkg::data_t                       S_AXI_RDATA,
    output logic [1:0]                                 S_AXI_RRESP,
    output logic                                       S_AXI_RVALID,
    input  logic                                       S_AXI_RREADY,

    // Core side
    input  obuf_regs_pkg::data_t                       id_reg,
    input  obuf_regs_pkg::data_t                       version_reg,
    output obuf_regs_pkg::data_t                       reset_reg,
    input  obuf_regs_pkg::data_t                       ip2cpu_flip_reg,
    output obuf_regs_pkg::data_t                       cpu2ip_flip_reg,
    input  obuf_regs_pkg::data_t                       ip2cpu_debug_reg,
    output obuf_regs_pkg::data_t                       cpu2ip_debug_reg,
    input  obuf_regs_pkg::data_t                       pktin_reg,
    output logic                                       pktin_reg_clear,
    input  obuf_regs_pkg::data_t                       pktout_reg,
    output logic                                       pktout_reg_clear,
    input  obuf_regs_pkg::port_stats_t [num_ports-1:0] port_stats,
    output logic [num_ports-1:0][obuf_regs_pkg::counters_per_port-1:0] port_stats_clear
);

    obuf_regs_pkg::wr_req_t wr_req;
    obuf_regs_pkg::rd_req_t rd_req;
    obuf_regs_pkg::data_t   rd_data;

    axil_write_channel #(
        .base_address (base_address)
    ) u_write (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .awaddr        (S_AXI_AWADDR),
        .awvalid       (S_AXI_AWVALID),
        .awready       (S_AXI_AWREADY),
        .wdata         (S_AXI_WDATA),
        .wstrb         (S_AXI_WSTRB),
        .wvalid        (S_AXI_WVALID),
        .wready        (S_AXI_WREADY),
        .bresp         (S_AXI_BRESP),
        .bvalid        (S_AXI_BVALID),
        .bready        (S_AXI_BREADY),
        .wr_req        (wr_req)
    );

    axil_read_channel #(
        .base_address (base_address)
    ) u_read (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .araddr        (S_AXI_ARADDR),
        .arvalid       (S_AXI_ARVALID),
        .arready       (S_AXI_ARREADY),
        .rdata         (S_AXI_RDATA),
        .rresp         (S_AXI_RRESP),
        .rvalid        (S_AXI_RVALID),
        .rready        (S_AXI_RREADY),
        .rd_req        (rd_req),
        .rd_data       (rd_data)
    );

    obuf_ctrl_regs u_ctrl (
        .S_AXI_ACLK       (S_AXI_ACLK),
        .S_AXI_ARESETN    (S_AXI_ARESETN),
        .wr_req           (wr_req),
        .reset_reg        (reset_reg),
        .cpu2ip_flip_reg  (cpu2ip_flip_reg),
        .cpu2ip_debug_reg (cpu2ip_debug_reg)
    );

    obuf_stats_readback #(
        .num_ports (num_ports)
    ) u_stats (
        .S_AXI_ACLK       (S_AXI_ACLK),
        .S_AXI_ARESETN    (S_AXI_ARESETN),
        .rd_req           (rd_req),
        .rd_data          (rd_data),
        .id_reg           (id_reg),
        .version_reg      (version_reg),
        .ip2cpu_flip_reg  (ip2cpu_flip_reg),
        .ip2cpu_debug_reg (ip2cpu_debug_reg),
        .pktin_reg        (pktin_reg),
        .pktout_reg       (pktout_reg),
        .port_stats       (port_stats),
        .pktin_reg_clear  (pktin_reg_clear),
        .pktout_reg_clear (pktout_reg_clear),
        .port_stats_clear (port_stats_clear)
    );

endmodule

//--- include/obuf_regs_tb_util.svh
`ifndef OBUF_REGS_TB_UTIL_SVH
`define OBUF_REGS_TB_UTIL_SVH

// Fibonacci LFSR with taps 32 22 2 1
function automatic logic next_lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
endfunction

function automatic logic [31:0] random_word();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
        w = {w[30:0], next_lfsr_bit()};
    end
    return w;
endfunction

task automatic check_value(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
    if (actual !== expected) begin
        $display("[ERROR] %0d ns: %s is %0h, expected %0h", $time, name, actual, expected);
        $display("Done: errors found");
        $fatal(1, "mismatch on %s", name);
    end
endtask

// Inverting twice restores the core-side values
task automatic invert_core_inputs();
    id_reg           = ~id_reg;
    version_reg      = ~version_reg;
    ip2cpu_flip_reg  = ~ip2cpu_flip_reg;
    ip2cpu_debug_reg = ~ip2cpu_debug_reg;
    pktin_reg        = ~pktin_reg;
    pktout_reg       = ~pktout_reg;
    port_stats       = ~port_stats;
endtask

////////////////////
// AXI-Lite master
////////////////////

// Called and returns on a falling edge
task automatic axi_write(input row_t r);
    logic [31:0] offset;
    logic        is_reset;
    offset   = r.addr ^ base;
    is_reset = (offset == obuf_regs_pkg::reg_reset_addr);
    S_AXI_AWADDR  = r.addr;
    S_AXI_AWVALID = 1'b1;
    S_AXI_WDATA   = r.data;
    S_AXI_WSTRB   = r.strb;
    S_AXI_WVALID  = 1'b1;
    do begin
        @(negedge S_AXI_ACLK);
        check_value("clear outputs", 64'(clear_vec), 64'd0);
        check_value("reset_reg", 64'(reset_reg), 64'd0);
    end while (!S_AXI_AWREADY);
    check_value("S_AXI_WREADY", 64'(S_AXI_WREADY), 64'd1);
    @(negedge S_AXI_ACLK);
    S_AXI_AWVALID = 1'b0;
    S_AXI_WVALID  = 1'b0;

    // Handshake edge has passed, so the register and response are updated
    if (offset == obuf_regs_pkg::reg_flip_addr) begin
        exp_flip = r.exp_val;
    end
    if (offset == obuf_regs_pkg::reg_debug_addr) begin
        exp_debug = r.exp_val;
    end
    check_value("S_AXI_BVALID", 64'(S_AXI_BVALID), 64'd1);
    check_value("S_AXI_BRESP", 64'(S_AXI_BRESP), 64'd0);
    check_value("reset_reg", 64'(reset_reg), is_reset ? 64'(r.exp_val) : 64'd0);
    check_value("cpu2ip_flip_reg", 64'(cpu2ip_flip_reg), 64'(exp_flip));
    check_value("cpu2ip_debug_reg", 64'(cpu2ip_debug_reg), 64'(exp_debug));
    check_value("clear outputs", 64'(clear_vec), 64'd0);

    repeat (r.hold) begin
        @(negedge S_AXI_ACLK);
        check_value("S_AXI_BVALID", 64'(S_AXI_BVALID), 64'd1);
        check_value("reset_reg", 64'(reset_reg), 64'd0);
        check_value("clear outputs", 64'(clear_vec), 64'd0);
    end
    S_AXI_BREADY = 1'b1;
    do begin
        @(negedge S_AXI_ACLK);
        check_value("reset_reg", 64'(reset_reg), 64'd0);
        check_value("clear outputs", 64'(clear_vec), 64'd0);
    end while (S_AXI_BVALID);
    S_AXI_BREADY = 1'b0;
endtask

task automatic axi_read(input row_t r);
    logic [num_counters+1:0] exp_clear;
    int                      step;
    exp_clear     = expected_clear(r.addr ^ base);
    S_AXI_ARADDR  = r.addr;
    S_AXI_ARVALID = 1'b1;
    do begin
        @(negedge S_AXI_ACLK);
        check_value("clear outputs", 64'(clear_vec), 64'd0);
    end while (!S_AXI_ARREADY);
    @(negedge S_AXI_ACLK);
    S_AXI_ARVALID = 1'b0;
    check_value("S_AXI_RVALID", 64'(S_AXI_RVALID), 64'd1);
    check_value("S_AXI_RRESP", 64'(S_AXI_RRESP), 64'd0);
    check_value("S_AXI_RDATA", 64'(S_AXI_RDATA), 64'(r.exp_val));
    check_value("clear outputs", 64'(clear_vec), 64'd0);

    // Core values move while data waits, so a reload would show up on RDATA
    if (r.hold > 0) begin
        invert_core_inputs();
    end

    // Clear pulse is due one falling edge after data shows up
    step = 0;
    repeat (r.hold) begin
        @(negedge S_AXI_ACLK);
        step++;
        check_value("S_AXI_RVALID", 64'(S_AXI_RVALID), 64'd1);
        check_value("S_AXI_RDATA", 64'(S_AXI_RDATA), 64'(r.exp_val));
        check_value("clear outputs", 64'(clear_vec), (step == 1) ? 64'(exp_clear) : 64'd0);
    end
    if (r.hold > 0) begin
        invert_core_inputs();
    end
    S_AXI_RREADY = 1'b1;
    do begin
        @(negedge S_AXI_ACLK);
        step++;
        check_value("clear outputs", 64'(clear_vec), (step == 1) ? 64'(exp_clear) : 64'd0);
    end while (S_AXI_RVALID);
    S_AXI_RREADY = 1'b0;
    while (step < 2) begin
        @(negedge S_AXI_ACLK);
        step++;
        check_value("clear outputs", 64'(clear_vec), (step == 1) ? 64'(exp_clear) : 64'd0);
    end
endtask

`endif

//--- dv/obuf_regs_tb.sv
`timescale 1ns/100ps

module obuf_regs_tb;

    localparam obuf_regs_pkg::addr_t base = 32'h4000_0000;
    localparam int num_ports    = 5;
    localparam int num_counters = num_ports * obuf_regs_pkg::counters_per_port;

    // One line of the stimulus table
    typedef struct packed {
        logic        is_write;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] exp_val;
        logic [3:0]  hold;
    } row_t;

    logic                       S_AXI_ACLK;
    logic                       S_AXI_ARESETN;
    obuf_regs_pkg::addr_t       S_AXI_AWADDR;
    logic                       S_AXI_AWVALID;
    logic                       S_AXI_AWREADY;
    obuf_regs_pkg::data_t       S_AXI_WDATA;
    obuf_regs_pkg::strb_t       S_AXI_WSTRB;
    logic                       S_AXI_WVALID;
    logic                       S_AXI_WREADY;
    logic [1:0]                 S_AXI_BRESP;
    logic                       S_AXI_BVALID;
    logic                       S_AXI_BREADY;
    obuf_regs_pkg::addr_t       S_AXI_ARADDR;
    logic                       S_AXI_ARVALID;
    logic                       S_AXI_ARREADY;
    obuf_regs_pkg::data_t       S_AXI_RDATA;
    logic [1:0]                 S_AXI_RRESP;
    logic                       S_AXI_RVALID;
    logic                       S_AXI_RREADY;

    obuf_regs_pkg::data_t       id_reg;
    obuf_regs_pkg::data_t       version_reg;
    obuf_regs_pkg::data_t       reset_reg;
    obuf_regs_pkg::data_t       ip2cpu_flip_reg;
    obuf_regs_pkg::data_t       cpu2ip_flip_reg;
    obuf_regs_pkg::data_t       ip2cpu_debug_reg;
    obuf_regs_pkg::data_t       cpu2ip_debug_reg;
    obuf_regs_pkg::data_t       pktin_reg;
    logic                       pktin_reg_clear;
    obuf_regs_pkg::data_t       pktout_reg;
    logic                       pktout_reg_clear;
    obuf_regs_pkg::port_stats_t [num_ports-1:0] port_stats;
    logic [num_ports-1:0][obuf_regs_pkg::counters_per_port-1:0] port_stats_clear;

    // All clear outputs in one vector, pktin first, then counters in address order
    logic [num_counters+1:0] clear_vec;

    logic [31:0] lfsr_state;
    logic [31:0] counter_vals [num_counters];
    logic [31:0] exp_flip;
    logic [31:0] exp_debug;
    row_t        rows [$];
    int          cycles = 0;
    int          cycle_limit = 1000;

    assign clear_vec = {port_stats_clear, pktout_reg_clear, pktin_reg_clear};

    `include "obuf_regs_tb_util.svh"

    obuf_regs_top #(
        .base_address (base),
        .num_ports    (num_ports)
    ) uut (
        .S_AXI_ACLK       (S_AXI_ACLK),
        .S_AXI_ARESETN    (S_AXI_ARESETN),
        .S_AXI_AWADDR     (S_AXI_AWADDR),
        .S_AXI_AWVALID    (S_AXI_AWVALID),
        .S_AXI_AWREADY    (S_AXI_AWREADY),
        .S_AXI_WDATA      (S_AXI_WDATA),
        .S_AXI_WSTRB      (S_AXI_WSTRB),
        .S_AXI_WVALID     (S_AXI_WVALID),
        .S_AXI_WREADY     (S_AXI_WREADY),
        .S_AXI_BRESP      (S_AXI_BRESP),
        .S_AXI_BVALID     (S_AXI_BVALID),
        .S_AXI_BREADY     (S_AXI_BREADY),
        .S_AXI_ARADDR     (S_AXI_ARADDR),
        .S_AXI_ARVALID    (S_AXI_ARVALID),
        .S_AXI_ARREADY    (S_AXI_ARREADY),
        .S_AXI_RDATA      (S_AXI_RDATA),
        .S_AXI_RRESP      (S_AXI_RRESP),
        .S_AXI_RVALID     (S_AXI_RVALID),
        .S_AXI_RREADY     (S_AXI_RREADY),
        .id_reg           (id_reg),
        .version_reg      (version_reg),
        .reset_reg        (reset_reg),
        .ip2cpu_flip_reg  (ip2cpu_flip_reg),
        .cpu2ip_flip_reg  (cpu2ip_flip_reg),
        .ip2cpu_debug_reg (ip2cpu_debug_reg),
        .cpu2ip_debug_reg (cpu2ip_debug_reg),
        .pktin_reg        (pktin_reg),
        .pktin_reg_clear  (pktin_reg_clear),
        .pktout_reg       (pktout_reg),
        .pktout_reg_clear (pktout_reg_clear),
        .port_stats       (port_stats),
        .port_stats_clear (port_stats_clear)
    );

    ////////////////////
    // Reference model of the register map
    ////////////////////

    // Counter number for an offset, or -1 when it is not a counter
    function automatic int counter_index(input logic [31:0] offset);
        logic [31:0] rel;
        rel = offset - obuf_regs_pkg::reg_port_base_addr;
        if (offset < obuf_regs_pkg::reg_port_base_addr || rel[1:0] != 2'b00
                || rel >= 32'(4 * num_counters)) begin
            return -1;
        end
        return int'(rel >> 2);
    endfunction

    function automatic logic [31:0] expected_read(input logic [31:0] offset);
        int idx;
        idx = counter_index(offset);
        if (idx >= 0) begin
            return counter_vals[idx];
        end
        case (offset)
            obuf_regs_pkg::reg_id_addr:      return id_reg;
            obuf_regs_pkg::reg_version_addr: return version_reg;
            obuf_regs_pkg::reg_flip_addr:    return ip2cpu_flip_reg;
            obuf_regs_pkg::reg_debug_addr:   return ip2cpu_debug_reg;
            obuf_regs_pkg::reg_pktin_addr:   return pktin_reg;
            obuf_regs_pkg::reg_pktout_addr:  return pktout_reg;
            default:                         return 32'hDEAD_BEEF;
        endcase
    endfunction

    function automatic logic [num_counters+1:0] expected_clear(input logic [31:0] offset);
        logic [num_counters+1:0] v;
        int                      idx;
        v   = '0;
        idx = counter_index(offset);
        if (offset == obuf_regs_pkg::reg_pktin_addr) begin
            v[0] = 1'b1;
        end else if (offset == obuf_regs_pkg::reg_pktout_addr) begin
            v[1] = 1'b1;
        end else if (idx >= 0) begin
            v[idx+2] = 1'b1;
        end
        return v;
    endfunction

    ////////////////////
    // Stimulus table
    ////////////////////

    task automatic add_read(input logic [31:0] offset, input logic [3:0] hold);
        row_t r;
        r.is_write = 1'b0;
        r.addr     = base ^ offset;
        r.data     = 32'h0;
        r.strb     = 4'h0;
        r.exp_val  = expected_read(offset);
        r.hold     = hold;
        rows.push_back(r);
    endtask

    task automatic add_write(input logic [31:0] offset, input logic [31:0] data,
                             input logic [3:0] strb, input logic [31:0] exp_val,
                             input logic [3:0] hold);
        row_t r;
        r.is_write = 1'b1;
        r.addr     = base ^ offset;
        r.data     = data;
        r.strb     = strb;
        r.exp_val  = exp_val;
        r.hold     = hold;
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_read(obuf_regs_pkg::reg_id_addr, 4'd0);
        add_read(obuf_regs_pkg::reg_version_addr, 4'd1);
        add_read(obuf_regs_pkg::reg_reset_addr, 4'd2);
        add_read(obuf_regs_pkg::reg_flip_addr, 4'd0);
        add_read(obuf_regs_pkg::reg_debug_addr, 4'd3);
        add_read(obuf_regs_pkg::reg_pktin_addr, 4'd1);
        add_read(obuf_regs_pkg::reg_pktout_addr, 4'd0);
        // Full strobe first, then partial strobes on top
        add_write(obuf_regs_pkg::reg_flip_addr, 32'hA5A5_5A5A, 4'hF, 32'hA5A5_5A5A, 4'd2);
        add_write(obuf_regs_pkg::reg_debug_addr, 32'h0F1E_2D3C, 4'hF, 32'h0F1E_2D3C, 4'd0);
        add_write(obuf_regs_pkg::reg_flip_addr, 32'h1122_3344, 4'h5, 32'hA522_5A44, 4'd5);
        add_write(obuf_regs_pkg::reg_debug_addr, 32'hFFFF_FFFF, 4'h2, 32'h0F1E_FF3C, 4'd1);
        add_write(obuf_regs_pkg::reg_reset_addr, 32'hCAFE_F00D, 4'hF, 32'hCAFE_F00D, 4'd3);
        add_write(obuf_regs_pkg::reg_reset_addr, 32'h1234_5678, 4'hC, 32'h1234_0000, 4'd0);
        // Core values come back, not the written ones
        add_read(obuf_regs_pkg::reg_flip_addr, 4'd1);
        add_read(obuf_regs_pkg::reg_debug_addr, 4'd0);
        for (int i = 0; i < num_counters; i++) begin
            add_read(obuf_regs_pkg::reg_port_base_addr + 32'(4 * i), 4'(i % 4));
        end
        // First word past the last counter, and one far out
        add_read(obuf_regs_pkg::reg_port_base_addr + 32'(4 * num_counters), 4'd2);
        add_read(32'h0000_00FC, 4'd0);
    endtask

    initial begin
        S_AXI_ACLK = 1'b0;
        forever #5 S_AXI_ACLK = ~S_AXI_ACLK;
    end

    // Run limit scales with the table
    always @(posedge S_AXI_ACLK) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped answering handshakes", cycles);
            $display("Done: errors found");
            $fatal(1, "run limit reached");
        end
    end

    initial begin
        S_AXI_ARESETN    = 1'b0;
        S_AXI_AWADDR     = '0;
        S_AXI_AWVALID    = 1'b0;
        S_AXI_WDATA      = '0;
        S_AXI_WSTRB      = '0;
        S_AXI_WVALID     = 1'b0;
        S_AXI_BREADY     = 1'b0;
        S_AXI_ARADDR     = '0;
        S_AXI_ARVALID    = 1'b0;
        S_AXI_RREADY     = 1'b0;
        exp_flip         = 32'h0;
        exp_debug        = 32'h0;

        // Core inputs from the LFSR
        lfsr_state       = 32'd81495;
        id_reg           = random_word();
        version_reg      = random_word();
        ip2cpu_flip_reg  = random_word();
        ip2cpu_debug_reg = random_word();
        pktin_reg        = random_word();
        pktout_reg       = random_word();
        for (int i = 0; i < num_counters; i++) begin
            counter_vals[i] = random_word();
        end
        for (int n = 0; n < num_ports; n++) begin
            port_stats[n].pkt_stored    = counter_vals[n * 7 + 0];
            port_stats[n].bytes_stored  = counter_vals[n * 7 + 1];
            port_stats[n].pkt_removed   = counter_vals[n * 7 + 2];
            port_stats[n].bytes_removed = counter_vals[n * 7 + 3];
            port_stats[n].pkt_dropped   = counter_vals[n * 7 + 4];
            port_stats[n].bytes_dropped = counter_vals[n * 7 + 5];
            port_stats[n].pkt_in_queue  = counter_vals[n * 7 + 6];
        end

        build_table();
        cycle_limit = 40 * rows.size() + 100;

        repeat (8) @(negedge S_AXI_ACLK);
        S_AXI_ARESETN = 1'b1;

        // State left by reset
        check_value("S_AXI_AWREADY", 64'(S_AXI_AWREADY), 64'd0);
        check_value("S_AXI_WREADY", 64'(S_AXI_WREADY), 64'd0);
        check_value("S_AXI_BVALID", 64'(S_AXI_BVALID), 64'd0);
        check_value("S_AXI_ARREADY", 64'(S_AXI_ARREADY), 64'd0);
        check_value("S_AXI_RVALID", 64'(S_AXI_RVALID), 64'd0);
        check_value("clear outputs", 64'(clear_vec), 64'd0);
        check_value("reset_reg", 64'(reset_reg), 64'd0);
        check_value("cpu2ip_flip_reg", 64'(cpu2ip_flip_reg), 64'd0);
        check_value("cpu2ip_debug_reg", 64'(cpu2ip_debug_reg), 64'd0);

        foreach (rows[i]) begin
            if (rows[i].is_write) begin
                axi_write(rows[i]);
            end else begin
                axi_read(rows[i]);
            end
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

//--- compile.f
+incdir+include
hdl/obuf_regs_pkg.sv
hdl/axil_write_channel.sv
hdl/axil_read_channel.sv
hdl/obuf_ctrl_regs.sv
hdl/obuf_stats_readback.sv
hdl/obuf_regs_top.sv
dv/obuf_regs_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the register block testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing \
    -f compile.f \
    --top-module obuf_regs_tb \
    -Mdir obj_dir \
    -o sim_obuf_regs

# The log decides the result, so a non-zero exit here must not stop the script
./obj_dir/sim_obuf_regs > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Done: errors found" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi
if ! grep -q "Done: no errors" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation PASSED"
